/* hw/sdhc_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// shared widths and transfer state encoding for the SD host DMA path
// imported by the transfer engine, the FIFO, the RAM model and the top
////////////////////////////////////////////////////////////////////////////

package sdhc_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////

   parameter int DATA_W = 32;     // one FIFO / RAM word
   parameter int ADDR_W = 64;     // system byte address
   parameter int LEN_W  = 16;     // transfer length in bytes

   // address step per transferred word
   parameter int BYTES_PER_WORD = DATA_W / 8;

   ////////////////////////////////////////////////////////////////////////////
   // transfer engine states
   ////////////////////////////////////////////////////////////////////////////

   // one-hot, one bit per state
   typedef enum logic [4:0] {
      IDLE       = 5'b00001,   // waiting for start, done high
      FIFO_RAM   = 5'b00010,   // card data into system memory
      RAM_FIFO   = 5'b00100,   // system memory out to the card
      WAIT_READ  = 5'b01000,   // FIFO ran dry during FIFO_RAM
      WAIT_WRITE = 5'b10000    // FIFO filled up during RAM_FIFO
   } xfer_state_t;

endpackage

/* hw/data_fifo.sv */
////////////////////////////////////////////////////////////////////////////
// show-ahead data FIFO between the card side and the transfer engine
// two push and two pop sources are ORed; only one of each is active
// per cycle since the engine and the card own opposite ends
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module data_fifo #(
   parameter int DEPTH = 8
) (
   input  logic                        CLK,
   input  logic                        reset,
   input  logic                        push_a,
   input  logic [sdhc_pkg::DATA_W-1:0] wdata_a,
   input  logic                        push_b,
   input  logic [sdhc_pkg::DATA_W-1:0] wdata_b,
   input  logic                        pop_a,
   input  logic                        pop_b,
   output logic [sdhc_pkg::DATA_W-1:0] rdata,
   output logic                        empty,
   output logic                        full
);
   import sdhc_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [DATA_W-1:0] mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [CNT_W-1:0]  count;
   logic [DATA_W-1:0] wdata;
   logic              do_push;
   logic              do_pop;

   // merge the two sources of each side
   assign wdata   = push_a ? wdata_a : wdata_b;
   assign do_push = (push_a | push_b) & ~full;    // dropped when full
   assign do_pop  = (pop_a | pop_b) & ~empty;     // dropped when empty

   assign rdata = mem[rd_ptr];   // show-ahead head word
   assign empty = (count == '0);
   assign full  = (count == CNT_W'(DEPTH));

   // storage array
   always_ff @(posedge CLK) begin
      if (do_push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // pointers and occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         // simultaneous push and pop leaves the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

/* hw/sys_ram.sv */
////////////////////////////////////////////////////////////////////////////
// system RAM model, word addressed, two independent ports
// port a is driven by the transfer engine, port b is the host port
// writes land on the clock edge, reads are combinational
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sys_ram #(
   parameter int WORDS = 64
) (
   input  logic                        CLK,
   input  logic                        a_we,
   input  logic [$clog2(WORDS)-1:0]    a_addr,
   input  logic [sdhc_pkg::DATA_W-1:0] a_wdata,
   output logic [sdhc_pkg::DATA_W-1:0] a_rdata,
   input  logic                        b_we,
   input  logic [$clog2(WORDS)-1:0]    b_addr,
   input  logic [sdhc_pkg::DATA_W-1:0] b_wdata,
   output logic [sdhc_pkg::DATA_W-1:0] b_rdata
);
   import sdhc_pkg::*;

   logic [DATA_W-1:0] mem [WORDS];

   // asynchronous read on both ports
   assign a_rdata = mem[a_addr];
   assign b_rdata = mem[b_addr];

   // port b written last, so it wins an address collision
   always_ff @(posedge CLK) begin
      if (a_we) begin
         mem[a_addr] <= a_wdata;
      end
      if (b_we) begin
         mem[b_addr] <= b_wdata;
      end
   end

endmodule

/* hw/dma_transfer.sv */
////////////////////////////////////////////////////////////////////////////
// transfer engine: moves 32-bit words between the data FIFO and system
// RAM, one word per unstalled cycle, stepping the byte address by four.
// start is taken in IDLE only; done is high whenever the engine is idle
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_transfer (
   input  logic                        CLK,
   input  logic                        reset,
   input  logic                        start,
   input  logic                        direction,     // 0 fifo->ram, 1 ram->fifo
   input  logic [sdhc_pkg::ADDR_W-1:0] address_init,
   input  logic [sdhc_pkg::LEN_W-1:0]  length,        // bytes
   input  logic [sdhc_pkg::DATA_W-1:0] fifo_rdata,
   input  logic                        empty,
   input  logic                        full,
   input  logic [sdhc_pkg::DATA_W-1:0] ram_rdata,
   output logic                        done,
   output logic [sdhc_pkg::ADDR_W-1:0] ram_address,
   output logic                        ram_write,
   output logic [sdhc_pkg::DATA_W-1:0] ram_wdata,
   output logic                        fifo_read,
   output logic                        fifo_write,
   output logic [sdhc_pkg::DATA_W-1:0] fifo_wdata
);
   import sdhc_pkg::*;

   xfer_state_t       state;
   xfer_state_t       next_state;
   logic [ADDR_W-1:0] end_address;   // address_init + length, latched on start
   logic              complete;
   logic              step;          // one word moves this cycle

   ////////////////////////////////////////////////////////////////////////////
   // datapath and strobes
   ////////////////////////////////////////////////////////////////////////////

   assign complete = (ram_address == end_address);

   // no strobes once the end address is reached
   assign fifo_read  = (state == FIFO_RAM) && !empty && !complete;
   assign fifo_write = (state == RAM_FIFO) && !full && !complete;

   assign ram_write  = fifo_read;    // head word goes straight to RAM
   assign ram_wdata  = fifo_rdata;
   assign fifo_wdata = ram_rdata;    // async RAM read at ram_address

   assign step = fifo_read | fifo_write;

   ////////////////////////////////////////////////////////////////////////////
   // next state
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (start) begin
               next_state = direction ? RAM_FIFO : FIFO_RAM;
            end
         end
         FIFO_RAM: begin
            if (complete) begin
               next_state = IDLE;
            end else if (empty) begin
               next_state = WAIT_READ;    // card side has not caught up
            end
         end
         RAM_FIFO: begin
            if (complete) begin
               next_state = IDLE;
            end else if (full) begin
               next_state = WAIT_WRITE;   // card side not draining
            end
         end
         WAIT_READ: begin
            if (!empty) begin
               next_state = FIFO_RAM;
            end
         end
         WAIT_WRITE: begin
            if (!full) begin
               next_state = RAM_FIFO;
            end
         end
         default: begin
            next_state = IDLE;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK) begin
      if (reset) begin
         state       <= IDLE;
         done        <= 1'b1;
         ram_address <= '0;
         end_address <= '0;
      end else begin
         state <= next_state;
         done  <= (next_state == IDLE);   // falls on start, rises on return

         if (state == IDLE && start) begin
            ram_address <= address_init;
            end_address <= address_init + {{(ADDR_W - LEN_W){1'b0}}, length};
         end else if (step) begin
            ram_address <= ram_address + ADDR_W'(BYTES_PER_WORD);
         end
         // address holds through the wait states
      end
   end

endmodule

/* hw/sdhc_dma_top.sv */
////////////////////////////////////////////////////////////////////////////
// DMA data path of the SD host: transfer engine, data FIFO and RAM model
// the card side drives the far end of the FIFO, the host port gives
// word access to RAM for preload and inspection
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sdhc_dma_top #(
   parameter int FIFO_DEPTH = 8,
   parameter int RAM_WORDS  = 64
) (
   input  logic                         CLK,
   input  logic                         reset,
   // control
   input  logic                         start,
   input  logic                         direction,
   input  logic [sdhc_pkg::ADDR_W-1:0]  address_init,
   input  logic [sdhc_pkg::LEN_W-1:0]   length,
   output logic                         done,
   // card side of the FIFO
   input  logic                         card_push,
   input  logic [sdhc_pkg::DATA_W-1:0]  card_wdata,
   input  logic                         card_pop,
   output logic [sdhc_pkg::DATA_W-1:0]  card_rdata,
   output logic                         card_empty,
   output logic                         card_full,
   // host port of the RAM
   input  logic                         host_we,
   input  logic [$clog2(RAM_WORDS)-1:0] host_addr,
   input  logic [sdhc_pkg::DATA_W-1:0]  host_wdata,
   output logic [sdhc_pkg::DATA_W-1:0]  host_rdata
);
   import sdhc_pkg::*;

   localparam int RAM_AW   = $clog2(RAM_WORDS);
   localparam int WORD_LSB = $clog2(BYTES_PER_WORD);

   logic [ADDR_W-1:0] ram_address;   // engine byte address
   logic              ram_write;
   logic [DATA_W-1:0] ram_wdata;
   logic [DATA_W-1:0] ram_rdata;
   logic              fifo_read;
   logic              fifo_write;
   logic [DATA_W-1:0] fifo_wdata;

   dma_transfer u_transfer (
      .CLK          (CLK),
      .reset        (reset),
      .start        (start),
      .direction    (direction),
      .address_init (address_init),
      .length       (length),
      .fifo_rdata   (card_rdata),    // one head word serves both sides
      .empty        (card_empty),
      .full         (card_full),
      .ram_rdata    (ram_rdata),
      .done         (done),
      .ram_address  (ram_address),
      .ram_write    (ram_write),
      .ram_wdata    (ram_wdata),
      .fifo_read    (fifo_read),
      .fifo_write   (fifo_write),
      .fifo_wdata   (fifo_wdata)
   );

   // engine on the a ports, card on the b ports
   data_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
      .CLK     (CLK),
      .reset   (reset),
      .push_a  (fifo_write),
      .wdata_a (fifo_wdata),
      .push_b  (card_push),
      .wdata_b (card_wdata),
      .pop_a   (fifo_read),
      .pop_b   (card_pop),
      .rdata   (card_rdata),
      .empty   (card_empty),
      .full    (card_full)
   );

   // word index from the byte address, upper bits wrap
   sys_ram #(.WORDS(RAM_WORDS)) u_ram (
      .CLK     (CLK),
      .a_we    (ram_write),
      .a_addr  (ram_address[WORD_LSB +: RAM_AW]),
      .a_wdata (ram_wdata),
      .a_rdata (ram_rdata),
      .b_we    (host_we),
      .b_addr  (host_addr),
      .b_wdata (host_wdata),
      .b_rdata (host_rdata)
   );

endmodule

/* sim/sdhc_dma_sva.sv */
////////////////////////////////////////////////////////////////////////////
// concurrent checks on the transfer engine, bound into dma_transfer
// covers the word step, resume after a stall and done timing
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module sdhc_dma_sva (
   input logic                        CLK,
   input logic                        reset,
   input sdhc_pkg::xfer_state_t       state,
   input logic                        done,
   input logic [sdhc_pkg::ADDR_W-1:0] ram_address,
   input logic [sdhc_pkg::ADDR_W-1:0] end_address,
   input logic                        empty,
   input logic                        full,
   input logic                        ram_write,
   input logic                        fifo_write
);
   import sdhc_pkg::*;

   // every moved word advances the byte address by one word
   word_step: assert property (@(posedge CLK) disable iff (reset)
      (ram_write || fifo_write) |=>
         (ram_address == $past(ram_address) + ADDR_W'(BYTES_PER_WORD)))
      else $error("address did not step by one word after a transfer strobe");

   // stalled engine moves a word in the cycle after the FIFO is ready
   read_resume: assert property (@(posedge CLK) disable iff (reset)
      (state == WAIT_READ && !empty) |=> ram_write)
      else $error("no RAM write after the FIFO stopped being empty");

   write_resume: assert property (@(posedge CLK) disable iff (reset)
      (state == WAIT_WRITE && !full) |=> fifo_write)
      else $error("no FIFO write after the FIFO stopped being full");

   // done only once the end address is reached
   done_at_end: assert property (@(posedge CLK) disable iff (reset)
      done |-> (ram_address == end_address))
      else $error("done high before the end address was reached");

   done_rises: assert property (@(posedge CLK) disable iff (reset)
      (!done && ram_address == end_address) |=> done)
      else $error("done did not rise after the end address was reached");

endmodule

/* sim/tb_sdhc_dma.sv */
////////////////////////////////////////////////////////////////////////////
// testbench for the SD host DMA path: a table of transfers run in a loop,
// card side driven with LFSR data and LFSR gaps, RAM read back through
// the host port and compared with a reference memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_sdhc_dma;
   import sdhc_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 4;
   localparam int FIFO_DEPTH   = 8;
   localparam int RAM_WORDS    = 64;
   localparam int RAM_AW       = $clog2(RAM_WORDS);
   localparam int NUM_TESTS    = 5;
   localparam int STALL_FACTOR = 8;   // worst case cycles per word with gaps

   typedef struct {
      string             name;
      logic              dir;      // 0 fifo->ram, 1 ram->fifo
      logic [ADDR_W-1:0] base;
      logic [LEN_W-1:0]  len;
      logic              gaps;     // random card-side gaps
   } test_t;

   logic                CLK;
   logic                reset;
   logic                start;
   logic                direction;
   logic [ADDR_W-1:0]   address_init;
   logic [LEN_W-1:0]    length;
   logic                done;
   logic                card_push;
   logic [DATA_W-1:0]   card_wdata;
   logic                card_pop;
   logic [DATA_W-1:0]   card_rdata;
   logic                card_empty;
   logic                card_full;
   logic                host_we;
   logic [RAM_AW-1:0]   host_addr;
   logic [DATA_W-1:0]   host_wdata;
   logic [DATA_W-1:0]   host_rdata;

   test_t             tests [NUM_TESTS];
   logic [DATA_W-1:0] ref_mem [RAM_WORDS];
   logic [31:0]       lfsr;
   logic              table_ready;
   int                errors;
   int                checks;

   sdhc_dma_top #(.FIFO_DEPTH(FIFO_DEPTH), .RAM_WORDS(RAM_WORDS)) u_dut (
      .CLK          (CLK),
      .reset        (reset),
      .start        (start),
      .direction    (direction),
      .address_init (address_init),
      .length       (length),
      .done         (done),
      .card_push    (card_push),
      .card_wdata   (card_wdata),
      .card_pop     (card_pop),
      .card_rdata   (card_rdata),
      .card_empty   (card_empty),
      .card_full    (card_full),
      .host_we      (host_we),
      .host_addr    (host_addr),
      .host_wdata   (host_wdata),
      .host_rdata   (host_rdata)
   );

   bind dma_transfer sdhc_dma_sva u_sva (
      .CLK         (CLK),
      .reset       (reset),
      .state       (state),
      .done        (done),
      .ram_address (ram_address),
      .end_address (end_address),
      .empty       (empty),
      .full        (full),
      .ram_write   (ram_write),
      .fifo_write  (fifo_write)
   );

   initial begin
      CLK = 1'b0;
      forever #(CLK_PERIOD / 2) CLK = ~CLK;
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [DATA_W-1:0] v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         v    = {v[DATA_W-2:0], lfsr[0]};   // one step per bit
         lfsr = lfsr_step(lfsr);
      end
   endtask

   task automatic set_row(input int idx, input string name, input logic dir,
                          input logic [ADDR_W-1:0] base, input logic [LEN_W-1:0] len,
                          input logic gaps);
      tests[idx].name = name;
      tests[idx].dir  = dir;
      tests[idx].base = base;
      tests[idx].len  = len;
      tests[idx].gaps = gaps;
   endtask

   task automatic compare_word(input string name, input logic [DATA_W-1:0] exp,
                               input logic [DATA_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERR %s expected %h actual %h", name, exp, act);
      end
   endtask

   // host port writes of LFSR data or a per-address pattern
   task automatic host_fill(input int first, input int count, input logic use_lfsr);
      logic [DATA_W-1:0] word;
      for (int i = first; i < first + count; i++) begin
         if (use_lfsr) begin
            take_bits(DATA_W, word);
         end else begin
            word = {8'h5a, 8'(i), 8'(i ^ 8'h3c), 8'(~i)};
         end
         @(negedge CLK);
         host_we    = 1'b1;
         host_addr  = RAM_AW'(i);
         host_wdata = word;
         ref_mem[i] = word;
      end
      @(negedge CLK);
      host_we = 1'b0;
   endtask

   task automatic check_ram(input string name);
      for (int i = 0; i < RAM_WORDS; i++) begin
         @(negedge CLK);
         host_addr = RAM_AW'(i);
         #(CLK_PERIOD / 4);   // async read settles mid low phase
         compare_word(name, ref_mem[i], host_rdata);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // one table row
   ////////////////////////////////////////////////////////////////////////////

   task automatic run_test(input int idx);
      test_t             t;
      int                nwords;
      int                base_word;
      int                moved;
      int                latency;
      logic              go;
      logic [DATA_W-1:0] word;
      logic [DATA_W-1:0] kept;
      t         = tests[idx];
      nwords    = int'(t.len) / BYTES_PER_WORD;
      base_word = int'(t.base >> 2) % RAM_WORDS;
      moved     = 0;
      latency   = 0;
      kept      = '0;
      if (t.dir && nwords > 0) begin
         host_fill(base_word, nwords, 1'b1);
      end
      @(negedge CLK);
      direction    = t.dir;
      address_init = t.base;
      length       = t.len;
      if (nwords == 0) begin
         take_bits(DATA_W, kept);   // must stay untouched in the FIFO
         card_push  = 1'b1;
         card_wdata = kept;
         @(negedge CLK);
      end else if (!t.dir && !t.gaps) begin
         while (moved < nwords) begin   // whole block queued before start
            take_bits(DATA_W, word);
            card_push                  = 1'b1;
            card_wdata                 = word;
            ref_mem[base_word + moved] = word;
            moved++;
            @(negedge CLK);
         end
      end
      card_push = 1'b0;
      start     = 1'b1;
      @(negedge CLK);
      start = 1'b0;
      checks++;
      if (done !== 1'b0) begin
         errors++;
         $display("%s: done did not fall after start", t.name);
      end
      while (done !== 1'b1 || moved < nwords) begin
         if (done !== 1'b1) latency++;
         card_push = 1'b0;
         card_pop  = 1'b0;
         if (moved < nwords) begin
            go = !t.gaps;
            if (t.gaps) begin
               take_bits(1, word);
               go = word[0];
            end
            if (!t.dir && go && !card_full) begin
               take_bits(DATA_W, word);
               card_push                  = 1'b1;
               card_wdata                 = word;
               ref_mem[base_word + moved] = word;
               moved++;
            end else if (t.dir && go && !card_empty) begin
               compare_word(t.name, ref_mem[base_word + moved], card_rdata);
               card_pop = 1'b1;
               moved++;
            end
         end
         @(negedge CLK);
      end
      card_push = 1'b0;
      card_pop  = 1'b0;
      // without stalls N words take N+1 cycles
      if (!t.gaps) begin
         checks++;
         if (latency != nwords + 1) begin
            errors++;
            $display("ERR %s expected %0d actual %0d", t.name, nwords + 1, latency);
         end
      end
      if (nwords == 0) begin
         compare_word(t.name, kept, card_rdata);
         card_pop = 1'b1;
         @(negedge CLK);
         card_pop = 1'b0;
      end
      checks++;
      if (card_empty !== 1'b1) begin
         errors++;
         $display("%s: FIFO holds extra words after the transfer", t.name);
      end
      check_ram(t.name);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence and watchdog
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      errors       = 0;
      checks       = 0;
      lfsr         = 32'h967f;
      table_ready  = 1'b0;
      reset        = 1'b1;
      start        = 1'b0;
      direction    = 1'b0;
      address_init = '0;
      length       = '0;
      card_push    = 1'b0;
      card_wdata   = '0;
      card_pop     = 1'b0;
      host_we      = 1'b0;
      host_addr    = '0;
      host_wdata   = '0;
      set_row(0, "fifo_to_ram_nogap", 1'b0, 64'h40, 16'd24, 1'b0);
      set_row(1, "ram_to_fifo_backpressure", 1'b1, 64'h80, 16'd64, 1'b1);
      set_row(2, "fifo_to_ram_underflow", 1'b0, 64'h10, 16'd48, 1'b1);
      set_row(3, "zero_len_fifo_to_ram", 1'b0, 64'hc0, 16'd0, 1'b0);
      set_row(4, "zero_len_ram_to_fifo", 1'b1, 64'h20, 16'd0, 1'b0);
      table_ready = 1'b1;
      repeat (RESET_CYCLES) @(negedge CLK);
      reset = 1'b0;
      @(negedge CLK);
      checks++;
      if (done !== 1'b1 || card_empty !== 1'b1 || card_full !== 1'b0) begin
         errors++;
         $display("wrong flags after reset: done %b empty %b full %b",
                  done, card_empty, card_full);
      end
      host_fill(0, RAM_WORDS, 1'b0);   // RAM has no reset
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(i);
      end
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      int limit;
      wait (table_ready);
      limit = RESET_CYCLES + RAM_WORDS + 10;
      for (int i = 0; i < NUM_TESTS; i++) begin
         limit += 2 * RAM_WORDS + 20 + STALL_FACTOR * (int'(tests[i].len) / BYTES_PER_WORD);
      end
      #(limit * CLK_PERIOD);
      $display("timeout: transfers did not finish within %0d cycles", limit);
      $display("errors: %0d of %0d checks", errors, checks);
      $display("sim failed");
      $finish;
   end

endmodule

/* tb.f */
hw/sdhc_pkg.sv
hw/data_fifo.sv
hw/sys_ram.sv
hw/dma_transfer.sv
hw/sdhc_dma_top.sv
sim/sdhc_dma_sva.sv
sim/tb_sdhc_dma.sv

/* Makefile */
# Verilator build for the SD host DMA testbench

VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       ?= tb_sdhc_dma
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := sim passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "pass line missing in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
